/* source/controlPkg.sv */
package controlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [4:0] shamtT;

    // fields the control unit needs from the instruction register
    typedef struct packed {
        opcodeT opcode;
        functT  funct;
        shamtT  shamt;
    } instrFields;

    typedef struct packed {
        logic zero;
        logic overflow;
    } aluFlags;

    // encodings follow the datapath ALU and shifter
    typedef enum logic [2:0] {
        ALU_LOAD = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_XOR  = 3'd6
    } aluOpT;

    typedef enum logic [2:0] {
        SHIFT_NOP    = 3'd0,
        SHIFT_LOADIN = 3'd1,
        SHIFT_LEFT   = 3'd2,
        SHIFT_LRIGHT = 3'd3,
        SHIFT_ARIGHT = 3'd4
    } shiftOpT;

    typedef enum logic [3:0] {
        REG_ALU, SHIFT, IMM_ALU, LOAD, STORE, LUI, BRANCH, JUMP, JUMP_REG, ILLEGAL
    } instrClassT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT      aluOp;
        shiftOpT    shiftOp;
        logic       shiftByRegister;  // sllv, srav
        logic       trapsOnOverflow;  // add, sub, addi
        logic       linkJump;         // jal
        logic       branchOnEqual;    // beq, else bne
    } decodedInstr;

    typedef enum logic [3:0] {
        FETCH, DECODE, EXECUTE, WRITE_BACK, MEM_ADDRESS, MEM_READ, MEM_WRITE,
        LOAD_UPPER, BRANCH_RESOLVE, JUMP_TARGET, JUMP_REGISTER,
        EPC_SAVE, VECTOR_READ, TRAP_JUMP
    } stateT;

    typedef logic [3:0] selT;

    localparam selT PC_FROM_ALU     = 4'd0;
    localparam selT PC_FROM_BRANCH  = 4'd1;
    localparam selT PC_FROM_JUMP    = 4'd2;
    localparam selT PC_FROM_TRAP    = 4'd3;

    localparam selT ADDR_PC         = 4'd0;
    localparam selT ADDR_ALUOUT     = 4'd1;
    localparam selT ADDR_VECTOR     = 4'd2; // exception vector slot

    localparam selT WB_ALU          = 4'd0;
    localparam selT WB_MDR          = 4'd1;
    localparam selT WB_UPPER        = 4'd2;
    localparam selT WB_SHIFTER      = 4'd3;
    localparam selT WB_PC           = 4'd4;

    localparam selT DST_RT          = 4'd0;
    localparam selT DST_RD          = 4'd1;
    localparam selT DST_LINK        = 4'd2; // $31

    localparam selT A_PC            = 4'd0;
    localparam selT A_REG           = 4'd1;

    localparam selT B_REG           = 4'd0;
    localparam selT B_FOUR          = 4'd1;
    localparam selT B_IMM           = 4'd2;
    localparam selT B_BRANCH_OFFSET = 4'd3;

    typedef logic causeT;

    localparam causeT CAUSE_ILLEGAL  = 1'b0;
    localparam causeT CAUSE_OVERFLOW = 1'b1;

    typedef struct packed {
        logic    pcWrite;
        logic    memWrite;
        logic    irWrite;
        logic    regWrite;
        logic    aWrite;
        logic    bWrite;
        logic    aluOutWrite;
        logic    mdrWrite;
        logic    epcWrite;
        selT     iorD;
        selT     pcSource;
        selT     aluSrcA;
        selT     aluSrcB;
        selT     memToReg;
        selT     regDst;
        aluOpT   aluOp;
        shiftOpT shiftOp;
        logic    shiftByRegister;
    } controlWord;

    typedef struct packed {
        logic  causeWrite;
        causeT intCause;
        causeT treatSrc;
    } trapControl;

endpackage

/* source/opcodeDecoder.sv */
`timescale 1ns/1ps

module opcodeDecoder (
    input  controlPkg::instrFields  instr,
    output controlPkg::decodedInstr decoded
);

    always_comb begin
        decoded = '{
            instrClass: controlPkg::ILLEGAL,
            aluOp:      controlPkg::ALU_LOAD,
            shiftOp:    controlPkg::SHIFT_NOP,
            default:    1'b0
        };

        case (instr.opcode)
            6'h00: begin // R-type sorted out by funct
                case (instr.funct)
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h26: begin
                        decoded.instrClass = controlPkg::REG_ALU;
                        case (instr.funct)
                            6'h20, 6'h21: decoded.aluOp = controlPkg::ALU_ADD;
                            6'h22, 6'h23: decoded.aluOp = controlPkg::ALU_SUB;
                            6'h24:        decoded.aluOp = controlPkg::ALU_AND;
                            default:      decoded.aluOp = controlPkg::ALU_XOR;
                        endcase
                        // only the signed forms trap
                        decoded.trapsOnOverflow = (instr.funct == 6'h20) || (instr.funct == 6'h22);
                    end
                    6'h00, 6'h04, 6'h03, 6'h07, 6'h02: begin
                        decoded.instrClass = controlPkg::SHIFT;
                        case (instr.funct)
                            6'h00, 6'h04: decoded.shiftOp = controlPkg::SHIFT_LEFT;
                            6'h03, 6'h07: decoded.shiftOp = controlPkg::SHIFT_ARIGHT;
                            default:      decoded.shiftOp = controlPkg::SHIFT_LRIGHT;
                        endcase
                        decoded.shiftByRegister = instr.funct[2]; // sllv, srav
                    end
                    6'h08: decoded.instrClass = controlPkg::JUMP_REG;
                    default: decoded.instrClass = controlPkg::ILLEGAL;
                endcase
            end
            6'h08, 6'h09, 6'h0c, 6'h0e: begin
                decoded.instrClass = controlPkg::IMM_ALU;
                case (instr.opcode)
                    6'h0c:   decoded.aluOp = controlPkg::ALU_AND;
                    6'h0e:   decoded.aluOp = controlPkg::ALU_XOR;
                    default: decoded.aluOp = controlPkg::ALU_ADD;
                endcase
                decoded.trapsOnOverflow = (instr.opcode == 6'h08); // addi
            end
            6'h23: begin
                decoded.instrClass = controlPkg::LOAD;
                decoded.aluOp = controlPkg::ALU_ADD; // base + offset
            end
            6'h2b: begin
                decoded.instrClass = controlPkg::STORE;
                decoded.aluOp = controlPkg::ALU_ADD;
            end
            6'h0f: decoded.instrClass = controlPkg::LUI;
            6'h04, 6'h05: begin
                decoded.instrClass = controlPkg::BRANCH;
                decoded.aluOp = controlPkg::ALU_SUB; // zero flag compares rs, rt
                decoded.branchOnEqual = !instr.opcode[0];
            end
            6'h02, 6'h03: begin
                decoded.instrClass = controlPkg::JUMP;
                decoded.linkJump = instr.opcode[0]; // jal
            end
            default: decoded.instrClass = controlPkg::ILLEGAL;
        endcase
    end

endmodule

/* source/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer #(
    parameter int memWaitCycles = 2
) (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::decodedInstr decoded,
    input  controlPkg::aluFlags     flags,
    output controlPkg::stateT       state,
    output logic                    lastWait,
    output controlPkg::trapControl  trap
);

    localparam int countWidth = (memWaitCycles > 0) ? $clog2(memWaitCycles + 1) : 1;
    localparam logic [countWidth-1:0] lastCount = countWidth'(memWaitCycles);

    controlPkg::stateT nextState;
    logic [countWidth-1:0] waitCount;   // shared by every memory wait
    controlPkg::causeT pendingCause;
    logic waiting;
    logic decodeTrap;
    logic overflowTrap;

    assign waiting = (state == controlPkg::FETCH) || (state == controlPkg::MEM_READ) ||
                     (state == controlPkg::VECTOR_READ);
    assign lastWait = waiting && (waitCount == lastCount);

    assign decodeTrap = (state == controlPkg::DECODE) &&
                        (decoded.instrClass == controlPkg::ILLEGAL);
    assign overflowTrap = (state == controlPkg::EXECUTE) && flags.overflow &&
                          decoded.trapsOnOverflow;

    always_comb begin
        trap.causeWrite = decodeTrap || overflowTrap;
        trap.intCause = overflowTrap ? controlPkg::CAUSE_OVERFLOW : controlPkg::CAUSE_ILLEGAL;
        // vector select only matters while jumping to the handler
        trap.treatSrc = (state == controlPkg::TRAP_JUMP) ? pendingCause
                                                         : controlPkg::CAUSE_ILLEGAL;
    end

    always_comb begin
        nextState = controlPkg::FETCH;
        case (state)
            controlPkg::FETCH:
                nextState = lastWait ? controlPkg::DECODE : controlPkg::FETCH;
            controlPkg::DECODE: begin
                case (decoded.instrClass)
                    controlPkg::REG_ALU,
                    controlPkg::SHIFT,
                    controlPkg::IMM_ALU:  nextState = controlPkg::EXECUTE;
                    controlPkg::LOAD,
                    controlPkg::STORE:    nextState = controlPkg::MEM_ADDRESS;
                    controlPkg::LUI:      nextState = controlPkg::LOAD_UPPER;
                    controlPkg::BRANCH:   nextState = controlPkg::BRANCH_RESOLVE;
                    controlPkg::JUMP:     nextState = controlPkg::JUMP_TARGET;
                    controlPkg::JUMP_REG: nextState = controlPkg::JUMP_REGISTER;
                    default:              nextState = controlPkg::EPC_SAVE;
                endcase
            end
            controlPkg::EXECUTE:
                nextState = overflowTrap ? controlPkg::EPC_SAVE : controlPkg::WRITE_BACK;
            controlPkg::MEM_ADDRESS:
                nextState = (decoded.instrClass == controlPkg::LOAD) ? controlPkg::MEM_READ
                                                                     : controlPkg::MEM_WRITE;
            controlPkg::MEM_READ:
                nextState = lastWait ? controlPkg::FETCH : controlPkg::MEM_READ;
            controlPkg::EPC_SAVE:
                nextState = controlPkg::VECTOR_READ;
            controlPkg::VECTOR_READ:
                nextState = lastWait ? controlPkg::TRAP_JUMP : controlPkg::VECTOR_READ;
            default:
                nextState = controlPkg::FETCH; // single cycle states
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= controlPkg::FETCH;
            waitCount <= '0;
            pendingCause <= controlPkg::CAUSE_ILLEGAL;
        end else begin
            state <= nextState;
            if (waiting && !lastWait)
                waitCount <= waitCount + 1'b1;
            else
                waitCount <= '0;
            if (trap.causeWrite)
                pendingCause <= trap.intCause;
        end
    end

    counterInRange: assert property (@(posedge clock) disable iff (reset)
        waitCount <= lastCount);

    // cause is recorded only on decode or execute, and the EPC save follows at once
    trapEntry: assert property (@(posedge clock) disable iff (reset)
        trap.causeWrite |->
            (state inside {controlPkg::DECODE, controlPkg::EXECUTE})
            ##1 (state == controlPkg::EPC_SAVE));

endmodule

/* source/controlWordGen.sv */
`timescale 1ns/1ps

module controlWordGen (
    input  controlPkg::stateT       state,
    input  logic                    lastWait,
    input  controlPkg::decodedInstr decoded,
    input  controlPkg::aluFlags     flags,
    output controlPkg::controlWord  control
);

    // nothing written and PC + 4 on the ALU
    localparam controlPkg::controlWord idleWord = '{
        iorD:            controlPkg::ADDR_PC,
        pcSource:        controlPkg::PC_FROM_ALU,
        aluSrcA:         controlPkg::A_PC,
        aluSrcB:         controlPkg::B_FOUR,
        memToReg:        controlPkg::WB_ALU,
        regDst:          controlPkg::DST_RT,
        aluOp:           controlPkg::ALU_LOAD,
        shiftOp:         controlPkg::SHIFT_NOP,
        default:         1'b0
    };

    logic branchTaken;

    assign branchTaken = (flags.zero == decoded.branchOnEqual);

    always_comb begin
        control = idleWord;
        case (state)
            controlPkg::FETCH: begin
                control.aluOp = controlPkg::ALU_ADD;
                control.pcWrite = lastWait;
                control.irWrite = lastWait; // instruction ready on the last wait
            end
            controlPkg::DECODE: begin
                control.aWrite = 1'b1;
                control.bWrite = 1'b1;
                control.aluOutWrite = 1'b1; // branch target
                control.aluSrcB = controlPkg::B_BRANCH_OFFSET;
                control.aluOp = controlPkg::ALU_ADD;
                control.shiftOp = controlPkg::SHIFT_LOADIN;
            end
            controlPkg::EXECUTE: begin
                control.aluOutWrite = 1'b1;
                control.aluSrcA = controlPkg::A_REG;
                control.aluSrcB = (decoded.instrClass == controlPkg::IMM_ALU) ? controlPkg::B_IMM
                                                                               : controlPkg::B_REG;
                control.aluOp = decoded.aluOp;
                control.shiftOp = decoded.shiftOp;
                control.shiftByRegister = decoded.shiftByRegister;
            end
            controlPkg::WRITE_BACK: begin
                control.regWrite = 1'b1;
                control.regDst = (decoded.instrClass == controlPkg::IMM_ALU) ? controlPkg::DST_RT
                                                                              : controlPkg::DST_RD;
                control.memToReg = (decoded.instrClass == controlPkg::SHIFT)
                                   ? controlPkg::WB_SHIFTER : controlPkg::WB_ALU;
            end
            controlPkg::MEM_ADDRESS: begin
                control.aluOutWrite = 1'b1;
                control.aluSrcA = controlPkg::A_REG;
                control.aluSrcB = controlPkg::B_IMM;
                control.aluOp = decoded.aluOp;
            end
            controlPkg::MEM_READ: begin
                control.iorD = controlPkg::ADDR_ALUOUT;
                control.mdrWrite = 1'b1;
                control.regWrite = lastWait;
                control.memToReg = controlPkg::WB_MDR;
            end
            controlPkg::MEM_WRITE: begin
                control.iorD = controlPkg::ADDR_ALUOUT;
                control.memWrite = 1'b1;
            end
            controlPkg::LOAD_UPPER: begin
                control.regWrite = 1'b1;
                control.memToReg = controlPkg::WB_UPPER;
            end
            controlPkg::BRANCH_RESOLVE: begin
                control.aluSrcA = controlPkg::A_REG;
                control.aluSrcB = controlPkg::B_REG;
                control.aluOp = decoded.aluOp;
                control.pcWrite = branchTaken;
                control.pcSource = branchTaken ? controlPkg::PC_FROM_BRANCH
                                               : controlPkg::PC_FROM_ALU;
            end
            controlPkg::JUMP_TARGET: begin
                control.pcWrite = 1'b1;
                control.pcSource = controlPkg::PC_FROM_JUMP;
                if (decoded.linkJump) begin
                    control.regWrite = 1'b1;
                    control.regDst = controlPkg::DST_LINK;
                    control.memToReg = controlPkg::WB_PC;
                end
            end
            controlPkg::JUMP_REGISTER: begin
                control.pcWrite = 1'b1;
                control.aluSrcA = controlPkg::A_REG; // rs straight through
            end
            controlPkg::EPC_SAVE: begin
                control.epcWrite = 1'b1;
                control.aluOp = controlPkg::ALU_SUB; // back to the faulting PC
            end
            controlPkg::VECTOR_READ: begin
                control.iorD = controlPkg::ADDR_VECTOR;
                control.mdrWrite = 1'b1;
            end
            controlPkg::TRAP_JUMP: begin
                control.pcWrite = 1'b1;
                control.pcSource = controlPkg::PC_FROM_TRAP;
            end
            default: control = idleWord;
        endcase
    end

    always_comb begin
        noMemRegClash: assert final (!(control.memWrite && control.regWrite));
        fetchMovesPc: assert final (!control.irWrite || control.pcWrite);
    end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit #(
    parameter int memWaitCycles = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::instrFields instr,
    input  controlPkg::aluFlags    flags,
    output controlPkg::controlWord control,
    output controlPkg::trapControl trap
);

    controlPkg::decodedInstr decoded;
    controlPkg::stateT state;
    logic lastWait;

    opcodeDecoder decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    controlSequencer #(
        .memWaitCycles (memWaitCycles)
    ) sequencer (
        .clock    (clock),
        .reset    (reset),
        .decoded  (decoded),
        .flags    (flags),
        .state    (state),
        .lastWait (lastWait),
        .trap     (trap)
    );

    controlWordGen wordGen (
        .state    (state),
        .lastWait (lastWait),
        .decoded  (decoded),
        .flags    (flags),
        .control  (control)
    );

endmodule

/* bench/controlChecks.sv */
`timescale 1ns/1ps

module controlChecks #(
    parameter int memWaitCycles = 2
) (
    input logic                   clock,
    input logic                   reset,
    input controlPkg::instrFields instr,
    input controlPkg::aluFlags    flags,
    input controlPkg::controlWord control,
    input controlPkg::trapControl trap
);

    int valueErrors = 0;
    int otherErrors = 0;

    function automatic logic isRegArith(controlPkg::instrFields i);
        return i.opcode == 6'h00 && i.funct inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h26};
    endfunction

    function automatic logic isShift(controlPkg::instrFields i);
        return i.opcode == 6'h00 && i.funct inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h07};
    endfunction

    function automatic logic isImmArith(controlPkg::instrFields i);
        return i.opcode inside {6'h08, 6'h09, 6'h0c, 6'h0e};
    endfunction

    // add, sub, addi
    function automatic logic trapsOnOverflow(controlPkg::instrFields i);
        return (i.opcode == 6'h00 && i.funct inside {6'h20, 6'h22}) || i.opcode == 6'h08;
    endfunction

    function automatic logic isLegal(controlPkg::instrFields i);
        if (i.opcode == 6'h00)
            return isRegArith(i) || isShift(i) || i.funct == 6'h08; // jr
        return isImmArith(i) ||
               i.opcode inside {6'h23, 6'h2b, 6'h0f, 6'h04, 6'h05, 6'h02, 6'h03};
    endfunction

    function automatic controlPkg::aluOpT expectedAluOp(controlPkg::instrFields i);
        if (isRegArith(i)) begin
            case (i.funct)
                6'h20, 6'h21: return controlPkg::ALU_ADD;
                6'h22, 6'h23: return controlPkg::ALU_SUB;
                6'h24:        return controlPkg::ALU_AND;
                default:      return controlPkg::ALU_XOR;
            endcase
        end
        case (i.opcode)
            6'h08, 6'h09: return controlPkg::ALU_ADD;
            6'h0c:        return controlPkg::ALU_AND;
            6'h0e:        return controlPkg::ALU_XOR;
            default:      return controlPkg::ALU_LOAD; // shifts leave the ALU alone
        endcase
    endfunction

    function automatic controlPkg::shiftOpT expectedShiftOp(controlPkg::instrFields i);
        if (!isShift(i))
            return controlPkg::SHIFT_NOP;
        case (i.funct)
            6'h00, 6'h04: return controlPkg::SHIFT_LEFT;
            6'h02:        return controlPkg::SHIFT_LRIGHT;
            default:      return controlPkg::SHIFT_ARIGHT;
        endcase
    endfunction

    function automatic logic [10:0] activeStrobes(controlPkg::controlWord c,
                                                  controlPkg::trapControl t);
        return {c.pcWrite, c.memWrite, c.irWrite, c.regWrite, c.aWrite, c.bWrite,
                c.aluOutWrite, c.mdrWrite, c.epcWrite, t.causeWrite, t.treatSrc};
    endfunction

    quietReset: assert property (@(posedge clock)
        (reset || $past(reset)) |-> activeStrobes(control, trap) == '0)
    else begin
        valueErrors++;
        $display("Fail strobes expected 000 got %h", activeStrobes($sampled(control),
                 $sampled(trap)));
    end

    firstFetch: assert property (@(posedge clock)
        $fell(reset) |-> ##memWaitCycles control.irWrite)
    else begin
        otherErrors++;
        $display("first instruction fetch did not finish on time after reset");
    end

    fetchPulse: assert property (@(posedge clock) disable iff (reset)
        control.irWrite |-> (control.pcWrite && control.pcSource == controlPkg::PC_FROM_ALU)
            ##1 !control.irWrite)
    else begin
        otherErrors++;
        $display("instruction fetch lacked a PC+4 update or lasted more than one cycle");
    end

    // regWrite lands in WRITE_BACK unless a trapping form overflowed
    arithResult: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 (isRegArith(instr) || isShift(instr) || isImmArith(instr))
            ##1 !(trapsOnOverflow(instr) && flags.overflow)
        |-> !trap.causeWrite
            ##1 (control.regWrite
            && control.regDst == (isImmArith(instr) ? controlPkg::DST_RT : controlPkg::DST_RD)
            && control.memToReg == (isShift(instr) ? controlPkg::WB_SHIFTER
                                                   : controlPkg::WB_ALU)))
    else begin
        valueErrors++;
        $display("Fail causeWrite/regWrite/regDst/memToReg for opcode %h funct %h got %h/%h/%h/%h",
                 $sampled(instr.opcode), $sampled(instr.funct), $sampled(trap.causeWrite),
                 $sampled(control.regWrite), $sampled(control.regDst),
                 $sampled(control.memToReg));
    end

    executeOps: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 (isRegArith(instr) || isShift(instr) || isImmArith(instr))
        |=> control.aluOp == expectedAluOp(instr) && control.shiftOp == expectedShiftOp(instr)
            && control.shiftByRegister
               == (instr.opcode == 6'h00 && instr.funct inside {6'h04, 6'h07}))
    else begin
        valueErrors++;
        $display("Fail aluOp/shiftOp got %h/%h expected %h/%h", $sampled(control.aluOp),
                 $sampled(control.shiftOp), expectedAluOp($sampled(instr)),
                 expectedShiftOp($sampled(instr)));
    end

    loadWord: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 instr.opcode == 6'h23
        |-> ##(memWaitCycles + 2) (control.regWrite && control.memToReg == controlPkg::WB_MDR
            && control.iorD == controlPkg::ADDR_ALUOUT))
    else begin
        valueErrors++;
        $display("Fail lw regWrite/memToReg/iorD got %h/%h/%h expected 1/%h/%h",
                 $sampled(control.regWrite), $sampled(control.memToReg), $sampled(control.iorD),
                 controlPkg::WB_MDR, controlPkg::ADDR_ALUOUT);
    end

    storeWord: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 instr.opcode == 6'h2b
        |-> !control.regWrite ##1 !control.regWrite
            ##1 (control.memWrite && !control.regWrite && control.iorD == controlPkg::ADDR_ALUOUT))
    else begin
        otherErrors++;
        $display("sw wrote a register or missed its memory write");
    end

    branch: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 instr.opcode inside {6'h04, 6'h05}
        |=> control.pcWrite == (flags.zero == (instr.opcode == 6'h04))
            && (!control.pcWrite || control.pcSource == controlPkg::PC_FROM_BRANCH))
    else begin
        valueErrors++;
        $display("Fail branch pcWrite/pcSource got %h/%h expected %h/%h",
                 $sampled(control.pcWrite), $sampled(control.pcSource),
                 $sampled(flags.zero) == ($sampled(instr.opcode) == 6'h04),
                 controlPkg::PC_FROM_BRANCH);
    end

    jump: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 instr.opcode inside {6'h02, 6'h03}
        |=> control.pcWrite && control.pcSource == controlPkg::PC_FROM_JUMP
            && control.regWrite == (instr.opcode == 6'h03)
            && (instr.opcode == 6'h02 || (control.regDst == controlPkg::DST_LINK
                && control.memToReg == controlPkg::WB_PC)))
    else begin
        valueErrors++;
        $display("Fail jump pcWrite/pcSource/regWrite/regDst/memToReg got %h/%h/%h/%h/%h",
                 $sampled(control.pcWrite), $sampled(control.pcSource),
                 $sampled(control.regWrite), $sampled(control.regDst),
                 $sampled(control.memToReg));
    end

    jumpRegister: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 (instr.opcode == 6'h00 && instr.funct == 6'h08)
        |=> control.pcWrite && control.pcSource == controlPkg::PC_FROM_ALU)
    else begin
        valueErrors++;
        $display("Fail jr pcWrite/pcSource got %h/%h expected 1/%h", $sampled(control.pcWrite),
                 $sampled(control.pcSource), controlPkg::PC_FROM_ALU);
    end

    loadUpper: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 instr.opcode == 6'h0f
        |=> control.regWrite && control.memToReg == controlPkg::WB_UPPER)
    else begin
        valueErrors++;
        $display("Fail lui regWrite/memToReg got %h/%h expected 1/%h",
                 $sampled(control.regWrite), $sampled(control.memToReg), controlPkg::WB_UPPER);
    end

    illegalTrap: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 !isLegal(instr)
        |-> (trap.causeWrite && trap.intCause == controlPkg::CAUSE_ILLEGAL)
            ##1 control.epcWrite
            ##(memWaitCycles + 2) (control.pcWrite
                && control.pcSource == controlPkg::PC_FROM_TRAP
                && trap.treatSrc == controlPkg::CAUSE_ILLEGAL))
    else begin
        otherErrors++;
        $display("illegal instruction did not run the full exception sequence");
    end

    overflowTrap: assert property (@(posedge clock) disable iff (reset)
        control.irWrite ##1 trapsOnOverflow(instr) ##1 flags.overflow
        |-> (trap.causeWrite && trap.intCause == controlPkg::CAUSE_OVERFLOW && !control.regWrite)
            ##1 (control.epcWrite && !control.regWrite)
            ##(memWaitCycles + 2) (control.pcWrite
                && control.pcSource == controlPkg::PC_FROM_TRAP
                && trap.treatSrc == controlPkg::CAUSE_OVERFLOW))
    else begin
        otherErrors++;
        $display("overflow did not run the full exception sequence or still wrote a register");
    end

endmodule

/* bench/controlUnitBench.sv */
`timescale 1ns/1ps

module controlUnitBench;

    localparam int memWaitCycles = 2;
    localparam int clockPeriod = 8;
    localparam int listLength = 27;
    localparam int runLength = 3 * listLength; // three passes so flags vary per instruction
    localparam int watchdogCycles = runLength * (memWaitCycles + 8) + 16;

    // {opcode, funct} pairs with immediate filler as funct of I and J entries
    localparam logic [11:0] codes [listLength] = '{
        // add addu sub subu and
        {6'h00, 6'h20}, {6'h00, 6'h21}, {6'h00, 6'h22}, {6'h00, 6'h23}, {6'h00, 6'h24},
        // xor sll sllv sra srav
        {6'h00, 6'h26}, {6'h00, 6'h00}, {6'h00, 6'h04}, {6'h00, 6'h03}, {6'h00, 6'h07},
        // srl addi addiu andi xori
        {6'h00, 6'h02}, {6'h08, 6'h15}, {6'h09, 6'h15}, {6'h0c, 6'h15}, {6'h0e, 6'h15},
        // lw sw lui beq bne
        {6'h23, 6'h15}, {6'h2b, 6'h15}, {6'h0f, 6'h15}, {6'h04, 6'h15}, {6'h05, 6'h15},
        // j jal jr, unused opcode, lb
        {6'h02, 6'h15}, {6'h03, 6'h15}, {6'h00, 6'h08}, {6'h3f, 6'h15}, {6'h20, 6'h15},
        // slt and break as unknown funct
        {6'h00, 6'h2a}, {6'h00, 6'h0d}
    };

    logic clock;
    logic reset;
    controlPkg::instrFields instr;
    controlPkg::aluFlags flags;
    controlPkg::controlWord control;
    controlPkg::trapControl trap;
    integer seed;
    logic loadNext;   // irWrite seen this cycle
    int issued;

    controlUnit #(
        .memWaitCycles (memWaitCycles)
    ) DUT (
        .clock   (clock),
        .reset   (reset),
        .instr   (instr),
        .flags   (flags),
        .control (control),
        .trap    (trap)
    );

    controlChecks #(
        .memWaitCycles (memWaitCycles)
    ) checks (
        .clock   (clock),
        .reset   (reset),
        .instr   (instr),
        .flags   (flags),
        .control (control),
        .trap    (trap)
    );

    task automatic finishRun(input logic timedOut);
        int failures;
        failures = checks.valueErrors + checks.otherErrors;
        $display("errors: %0d value, %0d other, %0d of %0d instructions issued",
                 checks.valueErrors, checks.otherErrors, issued, runLength);
        if (failures == 0 && !timedOut) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin
        seed = 32'h881f_4245;
        reset = 1'b1;
        instr = '0;
        flags = '0;
        loadNext = 1'b0;
        issued = 0;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        while (issued < runLength || !loadNext) begin
            @(posedge clock);
            #1;
            // instruction register follows the cycle after irWrite
            if (loadNext && issued < runLength) begin
                instr.opcode = codes[issued % listLength][11:6];
                instr.funct = codes[issued % listLength][5:0];
                instr.shamt = 5'($random(seed));
                issued++;
            end
            flags = 2'($random(seed));
            loadNext = control.irWrite;
        end
        repeat (2) @(posedge clock);
        finishRun(1'b0);
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("timeout: run still going after %0d cycles", watchdogCycles);
        finishRun(1'b1);
    end

endmodule

/* filelist.f */
source/controlPkg.sv
source/opcodeDecoder.sv
source/controlSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
bench/controlChecks.sv
bench/controlUnitBench.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - source/controlPkg.sv
  - source/opcodeDecoder.sv
  - source/controlSequencer.sv
  - source/controlWordGen.sv
  - source/controlUnit.sv
  - target: simulation
    files:
      - bench/controlChecks.sv
      - bench/controlUnitBench.sv
